/* common/cpu_glue_pkg.sv */
// CPU glue package with shared constants, width types, power state and port structs
package cpu_glue_pkg;

  ////////////////////////////////////////////////////////////
  // Sizing and timing constants
  ////////////////////////////////////////////////////////////

  // Flop stages in each interrupt synchronizer
  localparam int unsigned IRQ_SYNC_STAGES = 2;

  // Core held in reset this many cycles after external release
  localparam int unsigned RST_HOLD_CYCLES = 8;

  // Idle cycles needed in drain before the units sleep
  localparam int unsigned SLEEP_DELAY_CYCLES = 4;

  // Sequence timer width, must hold the larger delay
  localparam int unsigned TIMER_W = 4;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [TIMER_W-1:0] timer_cnt_t;

  // Interrupt lines, debug on top
  typedef struct packed {
    logic dbg;
    logic ext;
    logic sft;
    logic tmr;
  } irq_set_t;

  // One bit per clocked unit, for activity and for clock enables
  typedef struct packed {
    logic ifu;
    logic exu;
    logic lsu;
    logic biu;
    logic itcm;
    logic dtcm;
  } unit_set_t;

  // TCM light-sleep levels
  typedef struct packed {
    logic itcm;
    logic dtcm;
  } tcm_set_t;

  typedef enum logic [1:0] {
    ST_RESET_HOLD = 2'd0,
    ST_RUN        = 2'd1,
    ST_DRAIN      = 2'd2,
    ST_SLEEP      = 2'd3
  } glue_state_t;

endpackage

/* hw/power_ctrl/seq_timer.sv */
// Loadable down-counter giving a one-cycle done pulse after the loaded delay
`timescale 1ns/100ps

module seq_timer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     timer_start,
  input  cpu_glue_pkg::timer_cnt_t timer_load,
  output logic                     timer_done
);

  cpu_glue_pkg::timer_cnt_t cnt_q;
  logic busy_q;
  logic done_q;
  logic last_tick;

  // A zero load expires on the first tick as well
  assign last_tick = (cnt_q <= cpu_glue_pkg::timer_cnt_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (timer_start) begin
      // Restart wins over a count in flight
      cnt_q  <= timer_load;
      busy_q <= 1'b1;
      done_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q  <= cnt_q - cpu_glue_pkg::timer_cnt_t'(1);
      busy_q <= ~last_tick;
      done_q <= last_tick;
    end else begin
      done_q <= 1'b0;
    end
  end

  assign timer_done = done_q;

endmodule

/* hw/power_ctrl/power_ctrl_fsm.sv */
// Power state machine for core reset hold, run, drain on WFI and unit sleep
`timescale 1ns/100ps

module power_ctrl_fsm (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      core_wfi,
  input  cpu_glue_pkg::unit_set_t   unit_active,
  input  cpu_glue_pkg::irq_set_t    irq_r,
  input  logic                      timer_done,
  output cpu_glue_pkg::glue_state_t state,
  output logic                      timer_start,
  output cpu_glue_pkg::timer_cnt_t  timer_load,
  output logic                      rst_core,
  output logic                      sleeping
);

  cpu_glue_pkg::glue_state_t state_q;
  cpu_glue_pkg::glue_state_t state_d;

  // Set once the timer has been started for the current wait
  logic armed_q;
  logic armed_d;

  logic units_idle;
  logic wake;

  assign units_idle = ~|unit_active;
  // Pending interrupt or WFI dropped
  assign wake       = (|irq_r) | ~core_wfi;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    armed_d     = armed_q;
    timer_start = 1'b0;
    case (state_q)
      cpu_glue_pkg::ST_RESET_HOLD: begin
        // Start is ignored by the timer until reset is released
        if (!armed_q) begin
          timer_start = 1'b1;
          armed_d     = 1'b1;
        end else if (timer_done) begin
          state_d = cpu_glue_pkg::ST_RUN;
          armed_d = 1'b0;
        end
      end
      cpu_glue_pkg::ST_RUN: begin
        armed_d = 1'b0;
        if (core_wfi) begin
          state_d = cpu_glue_pkg::ST_DRAIN;
        end
      end
      cpu_glue_pkg::ST_DRAIN: begin
        if (wake) begin
          state_d = cpu_glue_pkg::ST_RUN;
          armed_d = 1'b0;
        end else if (!units_idle) begin
          // Unit woke up, wait starts over on the next idle cycle
          armed_d = 1'b0;
        end else if (!armed_q) begin
          timer_start = 1'b1;
          armed_d     = 1'b1;
        end else if (timer_done) begin
          state_d = cpu_glue_pkg::ST_SLEEP;
          armed_d = 1'b0;
        end
      end
      cpu_glue_pkg::ST_SLEEP: begin
        if (wake) begin
          state_d = cpu_glue_pkg::ST_RUN;
        end
      end
      default: begin
        state_d = cpu_glue_pkg::ST_RESET_HOLD;
        armed_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= cpu_glue_pkg::ST_RESET_HOLD;
      armed_q <= 1'b0;
    end else begin
      state_q <= state_d;
      armed_q <= armed_d;
    end
  end

  // Only two delays exist, picked by state
  assign timer_load = (state_q == cpu_glue_pkg::ST_RESET_HOLD) ?
                      cpu_glue_pkg::timer_cnt_t'(cpu_glue_pkg::RST_HOLD_CYCLES) :
                      cpu_glue_pkg::timer_cnt_t'(cpu_glue_pkg::SLEEP_DELAY_CYCLES);

  assign state    = state_q;
  assign rst_core = (state_q == cpu_glue_pkg::ST_RESET_HOLD);
  assign sleeping = (state_q == cpu_glue_pkg::ST_SLEEP);

endmodule

/* hw/irq_sync.sv */
// Multi-stage synchronizer bringing the asynchronous interrupt lines into clk
`timescale 1ns/100ps

module irq_sync (
  input  logic                   clk,
  input  logic                   reset,
  input  cpu_glue_pkg::irq_set_t irq_a,
  output cpu_glue_pkg::irq_set_t irq_r
);

  ////////////////////////////////////////////////////////////
  // Flop chain, one per line, all lines side by side
  ////////////////////////////////////////////////////////////

  cpu_glue_pkg::irq_set_t sync_q [cpu_glue_pkg::IRQ_SYNC_STAGES];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpu_glue_pkg::IRQ_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      // First stage may go metastable
      sync_q[0] <= irq_a;
      for (int i = 1; i < cpu_glue_pkg::IRQ_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage is the clean copy
  assign irq_r = sync_q[cpu_glue_pkg::IRQ_SYNC_STAGES-1];

endmodule

/* hw/clk_enable_gen.sv */
// Registered unit clock enables and TCM light-sleep levels from the power state
`timescale 1ns/100ps

module clk_enable_gen (
  input  logic                      clk,
  input  logic                      reset,
  input  cpu_glue_pkg::glue_state_t state,
  input  cpu_glue_pkg::unit_set_t   unit_active,
  input  logic                      core_cgstop,
  output cpu_glue_pkg::unit_set_t   unit_clk_en,
  output cpu_glue_pkg::tcm_set_t    tcm_ls
);

  cpu_glue_pkg::unit_set_t en_d;
  cpu_glue_pkg::tcm_set_t  ls_d;
  cpu_glue_pkg::tcm_set_t  tcm_active;

  assign tcm_active.itcm = unit_active.itcm;
  assign tcm_active.dtcm = unit_active.dtcm;

  ////////////////////////////////////////////////////////////
  // Gating decision
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (state)
      cpu_glue_pkg::ST_RESET_HOLD: begin
        // Clocks run so the core sees its reset
        en_d = '1;
        ls_d = '0;
      end
      cpu_glue_pkg::ST_SLEEP: begin
        en_d = '0;
        ls_d = '1;
      end
      default: begin
        // cgstop keeps every clock on and every TCM awake
        en_d = cpu_glue_pkg::unit_set_t'(unit_active | {$bits(en_d){core_cgstop}});
        ls_d = cpu_glue_pkg::tcm_set_t'(~tcm_active & {$bits(ls_d){~core_cgstop}});
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      unit_clk_en <= '0;
      tcm_ls      <= '0;
    end else begin
      unit_clk_en <= en_d;
      tcm_ls      <= ls_d;
    end
  end

endmodule

/* hw/cpu_glue_top.sv */
// Always-on CPU glue joining reset hold, interrupt sync and clock-enable control
`timescale 1ns/100ps

module cpu_glue_top (
  input  logic                    clk,
  input  logic                    reset,
  input  cpu_glue_pkg::irq_set_t  irq_a,
  input  cpu_glue_pkg::unit_set_t unit_active,
  input  logic                    core_wfi,
  input  logic                    core_cgstop,
  output logic                    rst_core,
  output logic                    sleeping,
  output cpu_glue_pkg::irq_set_t  irq_r,
  output cpu_glue_pkg::unit_set_t unit_clk_en,
  output cpu_glue_pkg::tcm_set_t  tcm_ls
);

  cpu_glue_pkg::glue_state_t state;
  cpu_glue_pkg::timer_cnt_t  timer_load;
  logic timer_start;
  logic timer_done;

  irq_sync u_irq_sync (
    .clk   (clk),
    .reset (reset),
    .irq_a (irq_a),
    .irq_r (irq_r)
  );

  ////////////////////////////////////////////////////////////
  // Power sequencing
  ////////////////////////////////////////////////////////////

  power_ctrl_fsm u_power_ctrl_fsm (
    .clk         (clk),
    .reset       (reset),
    .core_wfi    (core_wfi),
    .unit_active (unit_active),
    .irq_r       (irq_r),
    .timer_done  (timer_done),
    .state       (state),
    .timer_start (timer_start),
    .timer_load  (timer_load),
    .rst_core    (rst_core),
    .sleeping    (sleeping)
  );

  seq_timer u_seq_timer (
    .clk         (clk),
    .reset       (reset),
    .timer_start (timer_start),
    .timer_load  (timer_load),
    .timer_done  (timer_done)
  );

  clk_enable_gen u_clk_enable_gen (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .unit_active (unit_active),
    .core_cgstop (core_cgstop),
    .unit_clk_en (unit_clk_en),
    .tcm_ls      (tcm_ls)
  );

endmodule

/* sim/glue_checker.sv */
// Reference model for the CPU glue that compares every DUT output each cycle
`timescale 1ns/100ps

module glue_checker (
  input  logic                    clk,
  input  logic                    reset,
  input  cpu_glue_pkg::irq_set_t  irq_a,
  input  cpu_glue_pkg::unit_set_t unit_active,
  input  logic                    core_wfi,
  input  logic                    core_cgstop,
  input  logic                    rst_core,
  input  logic                    sleeping,
  input  cpu_glue_pkg::irq_set_t  irq_r,
  input  cpu_glue_pkg::unit_set_t unit_clk_en,
  input  cpu_glue_pkg::tcm_set_t  tcm_ls,
  input  logic                    run_done,
  output int                      error_count,
  output int                      check_count
);

  // Worst case from RUN into SLEEP is seven quiet edges
  localparam int REACH_LIMIT = cpu_glue_pkg::SLEEP_DELAY_CYCLES + 4;
  localparam int LAST_STAGE  = cpu_glue_pkg::IRQ_SYNC_STAGES - 1;

  cpu_glue_pkg::irq_set_t  irq_pipe [cpu_glue_pkg::IRQ_SYNC_STAGES];
  cpu_glue_pkg::unit_set_t exp_en;
  cpu_glue_pkg::tcm_set_t  exp_ls;
  logic exp_rst;
  logic exp_sleep;
  logic sleep_known;
  logic have_exp;
  logic prev_sleeping;
  logic reviewed;
  // Count of edges that sampled reset low, starting at 1
  int   rel_cnt;
  // Consecutive edges out of reset hold with WFI high and nothing pending
  int   quiet_cnt;
  int   sleep_entries;
  int   wake_count;

  initial begin
    error_count   = 0;
    check_count   = 0;
    have_exp      = 1'b0;
    prev_sleeping = 1'b0;
    reviewed      = 1'b0;
    rel_cnt       = 0;
    quiet_cnt     = 0;
    sleep_entries = 0;
    wake_count    = 0;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch %s: expected 0x%0h, actual 0x%0h at %0t",
               name, expected, actual, $time);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("error: %s at %0t", what, $time);
  endtask

  ////////////////////////////////////////////////////////////
  // Model step for the outputs after the coming edge
  ////////////////////////////////////////////////////////////

  task automatic advance_model();
    logic wake;
    logic quiet;
    wake  = (|irq_r) || !core_wfi;
    quiet = !rst_core && core_wfi && (unit_active == '0) && (irq_r == '0);
    if (reset) begin
      rel_cnt     = 0;
      quiet_cnt   = 0;
      exp_rst     = 1'b1;
      exp_en      = '0;
      exp_ls      = '0;
      sleep_known = 1'b1;
      exp_sleep   = 1'b0;
      for (int i = 0; i <= LAST_STAGE; i++) begin
        irq_pipe[i] = '0;
      end
    end else begin
      if (rel_cnt < 100000) begin
        rel_cnt++;
      end
      // Falls RST_HOLD_CYCLES+1 edges after the first released edge
      exp_rst = (rel_cnt <= cpu_glue_pkg::RST_HOLD_CYCLES + 1);
      for (int i = LAST_STAGE; i > 0; i--) begin
        irq_pipe[i] = irq_pipe[i-1];
      end
      irq_pipe[0] = irq_a;
      if (rst_core) begin
        exp_en = '1;
        exp_ls = '0;
      end else if (sleeping) begin
        exp_en = '0;
        exp_ls = '1;
      end else begin
        // cgstop turns every unit clock on
        if (core_cgstop) begin
          exp_en = '1;
        end else begin
          exp_en = unit_active;
        end
        exp_ls.itcm = !unit_active.itcm && !core_cgstop;
        exp_ls.dtcm = !unit_active.dtcm && !core_cgstop;
      end
      sleep_known = rst_core || sleeping;
      exp_sleep   = sleeping && !rst_core && !wake;
      quiet_cnt   = quiet ? quiet_cnt + 1 : 0;
    end
    prev_sleeping = sleeping;
    have_exp      = 1'b1;
  endtask

  always @(negedge clk) begin
    if (!reviewed) begin
      if (have_exp) begin
        compare_value("rst_core", exp_rst, rst_core);
        compare_value("irq_r", irq_pipe[LAST_STAGE], irq_r);
        compare_value("unit_clk_en", exp_en, unit_clk_en);
        compare_value("tcm_ls", exp_ls, tcm_ls);
        if (sleep_known) begin
          compare_value("sleeping", exp_sleep, sleeping);
        end
        if (sleeping === 1'b1 && prev_sleeping === 1'b0) begin
          sleep_entries++;
          if (quiet_cnt < cpu_glue_pkg::SLEEP_DELAY_CYCLES) begin
            report_failure($sformatf("sleeping rose after only %0d quiet cycles", quiet_cnt));
          end
        end
        if (sleeping === 1'b0 && prev_sleeping === 1'b1) begin
          wake_count++;
        end
        if (quiet_cnt == REACH_LIMIT && sleeping !== 1'b1) begin
          report_failure($sformatf("still awake after %0d quiet cycles", quiet_cnt));
        end
      end
      advance_model();
      if (run_done) begin
        if (sleep_entries == 0) begin
          report_failure("the units never went to sleep");
        end
        if (wake_count == 0) begin
          report_failure("the units never woke from sleep");
        end
        reviewed = 1'b1;
      end
    end
  end

endmodule

/* sim/cpu_glue_tb.sv */
// Testbench for the CPU glue with seeded random stimulus and a directed sleep test
`timescale 1ns/100ps

module cpu_glue_tb;

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 16;
  localparam int RANDOM_CYCLES = 3000;
  localparam int QUIET_CYCLES  = 30;
  localparam int IRQ_CYCLES    = 3;
  localparam int TAIL_CYCLES   = 30;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + RANDOM_CYCLES + QUIET_CYCLES +
                                 IRQ_CYCLES + TAIL_CYCLES + 1;

  logic                    clk;
  logic                    reset;
  cpu_glue_pkg::irq_set_t  irq_a;
  cpu_glue_pkg::unit_set_t unit_active;
  logic                    core_wfi;
  logic                    core_cgstop;
  logic                    rst_core;
  logic                    sleeping;
  cpu_glue_pkg::irq_set_t  irq_r;
  cpu_glue_pkg::unit_set_t unit_clk_en;
  cpu_glue_pkg::tcm_set_t  tcm_ls;
  logic                    run_done;
  int                      error_count;
  int                      check_count;
  integer                  seed;

  cpu_glue_top uut (
    .clk         (clk),
    .reset       (reset),
    .irq_a       (irq_a),
    .unit_active (unit_active),
    .core_wfi    (core_wfi),
    .core_cgstop (core_cgstop),
    .rst_core    (rst_core),
    .sleeping    (sleeping),
    .irq_r       (irq_r),
    .unit_clk_en (unit_clk_en),
    .tcm_ls      (tcm_ls)
  );

  glue_checker u_glue_checker (
    .clk         (clk),
    .reset       (reset),
    .irq_a       (irq_a),
    .unit_active (unit_active),
    .core_wfi    (core_wfi),
    .core_cgstop (core_cgstop),
    .rst_core    (rst_core),
    .sleeping    (sleeping),
    .irq_r       (irq_r),
    .unit_clk_en (unit_clk_en),
    .tcm_ls      (tcm_ls),
    .run_done    (run_done),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // True about once in n calls
  function automatic logic one_in(input int unsigned n);
    one_in = (($unsigned($random(seed)) % n) == 0);
  endfunction

  ////////////////////////////////////////////////////////////
  // Random stimulus, slow changes so drain and sleep happen
  ////////////////////////////////////////////////////////////

  task automatic drive_random_cycle();
    logic [3:0] irq_next;
    logic [5:0] act_next;
    logic       wfi_next;
    @(posedge clk);
    irq_next = irq_a;
    act_next = unit_active;
    wfi_next = core_wfi;
    for (int i = 0; i < 4; i++) begin
      if (irq_next[i]) begin
        irq_next[i] = !one_in(4);
      end else begin
        irq_next[i] = one_in(400);
      end
    end
    for (int i = 0; i < 6; i++) begin
      if (act_next[i]) begin
        act_next[i] = !one_in(4);
      end else begin
        act_next[i] = one_in(128);
      end
    end
    if (wfi_next) begin
      wfi_next = !one_in(60);
    end else begin
      wfi_next = one_in(20);
    end
    irq_a       <= cpu_glue_pkg::irq_set_t'(irq_next);
    unit_active <= cpu_glue_pkg::unit_set_t'(act_next);
    core_wfi    <= wfi_next;
    if (one_in(300)) begin
      core_cgstop <= !core_cgstop;
    end
  endtask

  initial begin
    seed        = 32'h4426_dded;
    reset       = 1'b1;
    irq_a       = '0;
    unit_active = '0;
    core_wfi    = 1'b0;
    core_cgstop = 1'b0;
    run_done    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    repeat (RANDOM_CYCLES) drive_random_cycle();

    // Directed sleep entry, then a single external interrupt
    @(posedge clk);
    irq_a       <= '0;
    unit_active <= '0;
    core_wfi    <= 1'b1;
    core_cgstop <= 1'b0;
    repeat (QUIET_CYCLES) @(posedge clk);
    irq_a <= cpu_glue_pkg::irq_set_t'(4'b0100);
    repeat (IRQ_CYCLES) @(posedge clk);
    irq_a <= '0;
    repeat (TAIL_CYCLES) @(posedge clk);
    run_done <= 1'b1;
    repeat (2) @(negedge clk);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * TOTAL_CYCLES * 3 / 2);
    $display("error: run did not finish within %0d cycles", TOTAL_CYCLES * 3 / 2);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* sources.f */
common/cpu_glue_pkg.sv
hw/power_ctrl/seq_timer.sv
hw/power_ctrl/power_ctrl_fsm.sv
hw/irq_sync.sv
hw/clk_enable_gen.sv
hw/cpu_glue_top.sv
sim/glue_checker.sv
sim/cpu_glue_tb.sv

/* Bender.yml */
package:
  name: cpu_glue

sources:
  - common/cpu_glue_pkg.sv
  - hw/power_ctrl/seq_timer.sv
  - hw/power_ctrl/power_ctrl_fsm.sv
  - hw/irq_sync.sv
  - hw/clk_enable_gen.sv
  - hw/cpu_glue_top.sv
  - target: simulation
    files:
      - sim/glue_checker.sv
      - sim/cpu_glue_tb.sv
